// File: common/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] word_t;       // pc, instruction, immediate, target
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [2:0]  alusel_t;
    typedef logic [6:0]  exc_cause_t;

    // 3R, matched on inst[31:15]
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [16:0] OP_XOR     = 17'h0002b;
    localparam logic [16:0] OP_BREAK   = 17'h00054;
    localparam logic [16:0] OP_SYSCALL = 17'h00056;

    // 2RI12, matched on inst[31:22]
    localparam logic [9:0] OP_SLTI   = 10'h008;
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;

    // 1RI20, matched on inst[31:25]
    localparam logic [6:0] OP_LU12I_W   = 7'h0a;
    localparam logic [6:0] OP_PCADDU12I = 7'h0e;

    // 2RI16 and I26, matched on inst[31:26]
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;

    localparam aluop_t ALU_NOP       = 8'd0;
    localparam aluop_t ALU_ADD_W     = 8'd1;
    localparam aluop_t ALU_SUB_W     = 8'd2;
    localparam aluop_t ALU_SLT       = 8'd3;
    localparam aluop_t ALU_AND       = 8'd4;
    localparam aluop_t ALU_OR        = 8'd5;
    localparam aluop_t ALU_XOR       = 8'd6;
    localparam aluop_t ALU_BREAK     = 8'd7;
    localparam aluop_t ALU_SYSCALL   = 8'd8;
    localparam aluop_t ALU_SLTI      = 8'd9;
    localparam aluop_t ALU_ADDI_W    = 8'd10;
    localparam aluop_t ALU_ANDI      = 8'd11;
    localparam aluop_t ALU_ORI       = 8'd12;
    localparam aluop_t ALU_LD_W      = 8'd13;
    localparam aluop_t ALU_ST_W      = 8'd14;
    localparam aluop_t ALU_LU12I_W   = 8'd15;
    localparam aluop_t ALU_PCADDU12I = 8'd16;
    localparam aluop_t ALU_JIRL      = 8'd17;
    localparam aluop_t ALU_B         = 8'd18;
    localparam aluop_t ALU_BL        = 8'd19;
    localparam aluop_t ALU_BEQ       = 8'd20;
    localparam aluop_t ALU_BNE       = 8'd21;

    localparam alusel_t SEL_NOP   = 3'd0;
    localparam alusel_t SEL_ARITH = 3'd1;
    localparam alusel_t SEL_LOGIC = 3'd2;
    localparam alusel_t SEL_MEM   = 3'd3;
    localparam alusel_t SEL_JUMP  = 3'd4;

    localparam exc_cause_t EXC_NONE = 7'h00;
    localparam exc_cause_t EXC_SYS  = 7'h0b;
    localparam exc_cause_t EXC_BRK  = 7'h0c;
    localparam exc_cause_t EXC_INE  = 7'h0d;

    localparam reg_addr_t RA = 5'd1;  // link register for bl

endpackage

// File: decoder/dec_3r.sv
`timescale 1ns/1ps

module dec_3r (
    input  decode_pkg::word_t     inst,
    output logic                  hit,
    output decode_pkg::aluop_t    aluop,
    output decode_pkg::alusel_t   alusel,
    output logic                  reg1_read_en,
    output decode_pkg::reg_addr_t reg1_read_addr,
    output logic                  reg2_read_en,
    output decode_pkg::reg_addr_t reg2_read_addr,
    output logic                  reg_write_en,
    output decode_pkg::reg_addr_t reg_write_addr
);
    import decode_pkg::*;

    logic uses_regs;

    always_comb begin
        hit = 1'b1;
        case (inst[31:15])
            OP_ADD_W:   {aluop, alusel} = {ALU_ADD_W, SEL_ARITH};
            OP_SUB_W:   {aluop, alusel} = {ALU_SUB_W, SEL_ARITH};
            OP_SLT:     {aluop, alusel} = {ALU_SLT, SEL_ARITH};
            OP_AND:     {aluop, alusel} = {ALU_AND, SEL_LOGIC};
            OP_OR:      {aluop, alusel} = {ALU_OR, SEL_LOGIC};
            OP_XOR:     {aluop, alusel} = {ALU_XOR, SEL_LOGIC};
            OP_BREAK:   {aluop, alusel} = {ALU_BREAK, SEL_NOP};
            OP_SYSCALL: {aluop, alusel} = {ALU_SYSCALL, SEL_NOP};
            default: begin
                hit             = 1'b0;
                {aluop, alusel} = {ALU_NOP, SEL_NOP};
            end
        endcase
    end

    // syscall and break carry a code field, not registers
    assign uses_regs = hit && aluop != ALU_SYSCALL && aluop != ALU_BREAK;

    assign reg1_read_en   = uses_regs;
    assign reg1_read_addr = uses_regs ? inst[9:5] : '0;    // rj
    assign reg2_read_en   = uses_regs;
    assign reg2_read_addr = uses_regs ? inst[14:10] : '0;  // rk
    assign reg_write_en   = uses_regs;
    assign reg_write_addr = uses_regs ? inst[4:0] : '0;    // rd

endmodule

// File: decoder/dec_imm_alu.sv
`timescale 1ns/1ps

module dec_imm_alu (
    input  decode_pkg::word_t     inst,
    output logic                  hit,
    output decode_pkg::aluop_t    aluop,
    output decode_pkg::alusel_t   alusel,
    output decode_pkg::word_t     imm,
    output logic                  reg1_read_en,
    output decode_pkg::reg_addr_t reg1_read_addr,
    output logic                  reg2_read_en,
    output decode_pkg::reg_addr_t reg2_read_addr,
    output logic                  reg_write_en,
    output decode_pkg::reg_addr_t reg_write_addr
);
    import decode_pkg::*;

    logic is_2ri12, is_1ri20, is_store, is_zext;

    always_comb begin
        is_2ri12 = 1'b1;
        is_1ri20 = 1'b0;
        case (inst[31:22])
            OP_SLTI:   {aluop, alusel} = {ALU_SLTI, SEL_ARITH};
            OP_ADDI_W: {aluop, alusel} = {ALU_ADDI_W, SEL_ARITH};
            OP_ANDI:   {aluop, alusel} = {ALU_ANDI, SEL_LOGIC};
            OP_ORI:    {aluop, alusel} = {ALU_ORI, SEL_LOGIC};
            OP_LD_W:   {aluop, alusel} = {ALU_LD_W, SEL_MEM};
            OP_ST_W:   {aluop, alusel} = {ALU_ST_W, SEL_MEM};
            default: begin
                is_2ri12 = 1'b0;
                is_1ri20 = 1'b1;
                case (inst[31:25])
                    OP_LU12I_W:   {aluop, alusel} = {ALU_LU12I_W, SEL_ARITH};
                    OP_PCADDU12I: {aluop, alusel} = {ALU_PCADDU12I, SEL_ARITH};
                    default: begin
                        is_1ri20        = 1'b0;
                        {aluop, alusel} = {ALU_NOP, SEL_NOP};
                    end
                endcase
            end
        endcase
    end

    assign hit      = is_2ri12 | is_1ri20;
    assign is_store = (aluop == ALU_ST_W);
    assign is_zext  = (aluop == ALU_ANDI) || (aluop == ALU_ORI);  // logic ops are unsigned

    assign imm = is_1ri20 ? {inst[24:5], 12'd0} :
                 !is_2ri12 ? '0 :
                 is_zext ? {20'd0, inst[21:10]} : {{20{inst[21]}}, inst[21:10]};

    assign reg1_read_en   = is_2ri12;
    assign reg1_read_addr = is_2ri12 ? inst[9:5] : '0;
    assign reg2_read_en   = is_store;
    assign reg2_read_addr = is_store ? inst[4:0] : '0;  // store data comes from rd
    assign reg_write_en   = hit & ~is_store;
    assign reg_write_addr = reg_write_en ? inst[4:0] : '0;

endmodule

// File: decoder/dec_branch.sv
`timescale 1ns/1ps

module dec_branch (
    input  decode_pkg::word_t     inst,
    output logic                  hit,
    output decode_pkg::aluop_t    aluop,
    output decode_pkg::alusel_t   alusel,
    output decode_pkg::word_t     imm,
    output logic                  reg1_read_en,
    output decode_pkg::reg_addr_t reg1_read_addr,
    output logic                  reg2_read_en,
    output decode_pkg::reg_addr_t reg2_read_addr,
    output logic                  reg_write_en,
    output decode_pkg::reg_addr_t reg_write_addr
);
    import decode_pkg::*;

    logic is_jirl, is_cmp, is_i26, is_bl;

    always_comb begin
        hit = 1'b1;
        case (inst[31:26])
            OP_JIRL: aluop = ALU_JIRL;
            OP_B:    aluop = ALU_B;
            OP_BL:   aluop = ALU_BL;
            OP_BEQ:  aluop = ALU_BEQ;
            OP_BNE:  aluop = ALU_BNE;
            default: begin
                hit   = 1'b0;
                aluop = ALU_NOP;
            end
        endcase
    end

    assign alusel  = hit ? SEL_JUMP : SEL_NOP;
    assign is_jirl = (aluop == ALU_JIRL);
    assign is_bl   = (aluop == ALU_BL);
    assign is_i26  = is_bl || aluop == ALU_B;
    assign is_cmp  = (aluop == ALU_BEQ) || (aluop == ALU_BNE);

    // offs26 has its high ten bits in inst[9:0]
    assign imm = is_i26 ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00} :
                 hit    ? {{14{inst[25]}}, inst[25:10], 2'b00} : '0;

    assign reg1_read_en   = is_jirl | is_cmp;
    assign reg1_read_addr = reg1_read_en ? inst[9:5] : '0;
    assign reg2_read_en   = is_cmp;
    assign reg2_read_addr = is_cmp ? inst[4:0] : '0;  // compare rj against rd
    assign reg_write_en   = is_jirl | is_bl;
    assign reg_write_addr = is_bl ? RA : (is_jirl ? inst[4:0] : '0);

endmodule

// File: decoder/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  decode_pkg::word_t      pc,
    input  decode_pkg::word_t      inst,
    input  logic [1:0]             is_exception,
    input  decode_pkg::exc_cause_t pc_exception_cause,
    input  decode_pkg::exc_cause_t instbuffer_exception_cause,
    input  logic                   pre_taken,
    input  decode_pkg::word_t      pre_addr,
    input  logic                   hit_3r,
    input  decode_pkg::aluop_t     aluop_3r,
    input  decode_pkg::alusel_t    alusel_3r,
    input  logic                   reg1_read_en_3r,
    input  logic                   reg2_read_en_3r,
    input  logic                   reg_write_en_3r,
    input  decode_pkg::reg_addr_t  reg1_read_addr_3r,
    input  decode_pkg::reg_addr_t  reg2_read_addr_3r,
    input  decode_pkg::reg_addr_t  reg_write_addr_3r,
    input  logic                   hit_ia,
    input  decode_pkg::aluop_t     aluop_ia,
    input  decode_pkg::alusel_t    alusel_ia,
    input  decode_pkg::word_t      imm_ia,
    input  logic                   reg1_read_en_ia,
    input  logic                   reg2_read_en_ia,
    input  logic                   reg_write_en_ia,
    input  decode_pkg::reg_addr_t  reg1_read_addr_ia,
    input  decode_pkg::reg_addr_t  reg2_read_addr_ia,
    input  decode_pkg::reg_addr_t  reg_write_addr_ia,
    input  logic                   hit_br,
    input  decode_pkg::aluop_t     aluop_br,
    input  decode_pkg::alusel_t    alusel_br,
    input  decode_pkg::word_t      imm_br,
    input  logic                   reg1_read_en_br,
    input  logic                   reg2_read_en_br,
    input  logic                   reg_write_en_br,
    input  decode_pkg::reg_addr_t  reg1_read_addr_br,
    input  decode_pkg::reg_addr_t  reg2_read_addr_br,
    input  decode_pkg::reg_addr_t  reg_write_addr_br,
    output logic                   out_valid,
    input  logic                   out_ready,
    output decode_pkg::word_t      pc_out,
    output decode_pkg::aluop_t     aluop,
    output decode_pkg::alusel_t    alusel,
    output decode_pkg::word_t      imm,
    output logic                   reg1_read_en,
    output logic                   reg2_read_en,
    output logic                   reg_write_en,
    output decode_pkg::reg_addr_t  reg1_read_addr,
    output decode_pkg::reg_addr_t  reg2_read_addr,
    output decode_pkg::reg_addr_t  reg_write_addr,
    output logic [2:0]             is_exception_out,
    output decode_pkg::exc_cause_t pc_exception_cause_out,
    output decode_pkg::exc_cause_t instbuffer_exception_cause_out,
    output decode_pkg::exc_cause_t decoder_exception_cause_out,
    output logic                   pre_taken_out,
    output decode_pkg::word_t      pre_addr_out
);
    import decode_pkg::*;

    localparam int RES_W = 61;  // aluop, alusel, imm, three enable/addr pairs

    logic [RES_W-1:0] res_3r, res_ia, res_br, res;
    exc_cause_t       dec_cause;
    logic             accept;

    assign res_3r = {aluop_3r, alusel_3r, 32'd0,
                     reg1_read_en_3r, reg1_read_addr_3r,
                     reg2_read_en_3r, reg2_read_addr_3r,
                     reg_write_en_3r, reg_write_addr_3r};
    assign res_ia = {aluop_ia, alusel_ia, imm_ia,
                     reg1_read_en_ia, reg1_read_addr_ia,
                     reg2_read_en_ia, reg2_read_addr_ia,
                     reg_write_en_ia, reg_write_addr_ia};
    assign res_br = {aluop_br, alusel_br, imm_br,
                     reg1_read_en_br, reg1_read_addr_br,
                     reg2_read_en_br, reg2_read_addr_br,
                     reg_write_en_br, reg_write_addr_br};

    assign res = hit_3r ? res_3r :
                 hit_ia ? res_ia :
                 hit_br ? res_br : '0;  // illegal word decodes to all zero

    always_comb begin
        if (!(hit_3r | hit_ia | hit_br)) begin
            dec_cause = EXC_INE;
        end else if (hit_3r && aluop_3r == ALU_SYSCALL) begin
            dec_cause = EXC_SYS;
        end else if (hit_3r && aluop_3r == ALU_BREAK) begin
            dec_cause = EXC_BRK;
        end else begin
            dec_cause = EXC_NONE;
        end
    end

    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            {aluop, alusel, imm,
             reg1_read_en, reg1_read_addr,
             reg2_read_en, reg2_read_addr,
             reg_write_en, reg_write_addr} <= res;
            pc_out                         <= pc;
            is_exception_out               <= {is_exception, dec_cause != EXC_NONE};
            pc_exception_cause_out         <= pc_exception_cause;
            instbuffer_exception_cause_out <= instbuffer_exception_cause;
            decoder_exception_cause_out    <= dec_cause;
            pre_taken_out                  <= pre_taken;
            pre_addr_out                   <= pre_addr;
        end
    end

endmodule

// File: decoder/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  decode_pkg::word_t      pc,
    input  decode_pkg::word_t      inst,
    input  logic [1:0]             is_exception,
    input  decode_pkg::exc_cause_t pc_exception_cause,
    input  decode_pkg::exc_cause_t instbuffer_exception_cause,
    input  logic                   pre_taken,
    input  decode_pkg::word_t      pre_addr,
    output logic                   out_valid,
    input  logic                   out_ready,
    output decode_pkg::word_t      pc_out,
    output decode_pkg::aluop_t     aluop,
    output decode_pkg::alusel_t    alusel,
    output decode_pkg::word_t      imm,
    output logic                   reg1_read_en,
    output logic                   reg2_read_en,
    output logic                   reg_write_en,
    output decode_pkg::reg_addr_t  reg1_read_addr,
    output decode_pkg::reg_addr_t  reg2_read_addr,
    output decode_pkg::reg_addr_t  reg_write_addr,
    output logic [2:0]             is_exception_out,
    output decode_pkg::exc_cause_t pc_exception_cause_out,
    output decode_pkg::exc_cause_t instbuffer_exception_cause_out,
    output decode_pkg::exc_cause_t decoder_exception_cause_out,
    output logic                   pre_taken_out,
    output decode_pkg::word_t      pre_addr_out
);
    import decode_pkg::*;

    logic      hit_3r, hit_ia, hit_br;
    aluop_t    aluop_3r, aluop_ia, aluop_br;
    alusel_t   alusel_3r, alusel_ia, alusel_br;
    word_t     imm_ia, imm_br;
    logic      reg1_read_en_3r, reg1_read_en_ia, reg1_read_en_br;
    logic      reg2_read_en_3r, reg2_read_en_ia, reg2_read_en_br;
    logic      reg_write_en_3r, reg_write_en_ia, reg_write_en_br;
    reg_addr_t reg1_read_addr_3r, reg1_read_addr_ia, reg1_read_addr_br;
    reg_addr_t reg2_read_addr_3r, reg2_read_addr_ia, reg2_read_addr_br;
    reg_addr_t reg_write_addr_3r, reg_write_addr_ia, reg_write_addr_br;

    dec_3r u_dec_3r (
        .inst,
        .hit            (hit_3r),
        .aluop          (aluop_3r),
        .alusel         (alusel_3r),
        .reg1_read_en   (reg1_read_en_3r),
        .reg1_read_addr (reg1_read_addr_3r),
        .reg2_read_en   (reg2_read_en_3r),
        .reg2_read_addr (reg2_read_addr_3r),
        .reg_write_en   (reg_write_en_3r),
        .reg_write_addr (reg_write_addr_3r)
    );

    dec_imm_alu u_dec_imm_alu (
        .inst,
        .hit            (hit_ia),
        .aluop          (aluop_ia),
        .alusel         (alusel_ia),
        .imm            (imm_ia),
        .reg1_read_en   (reg1_read_en_ia),
        .reg1_read_addr (reg1_read_addr_ia),
        .reg2_read_en   (reg2_read_en_ia),
        .reg2_read_addr (reg2_read_addr_ia),
        .reg_write_en   (reg_write_en_ia),
        .reg_write_addr (reg_write_addr_ia)
    );

    dec_branch u_dec_branch (
        .inst,
        .hit            (hit_br),
        .aluop          (aluop_br),
        .alusel         (alusel_br),
        .imm            (imm_br),
        .reg1_read_en   (reg1_read_en_br),
        .reg1_read_addr (reg1_read_addr_br),
        .reg2_read_en   (reg2_read_en_br),
        .reg2_read_addr (reg2_read_addr_br),
        .reg_write_en   (reg_write_en_br),
        .reg_write_addr (reg_write_addr_br)
    );

    // names match one to one
    decode_ctrl u_decode_ctrl (.*);

endmodule

// File: verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: verification/decode_checker.sv
`timescale 1ns/1ps

module decode_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input decode_pkg::word_t      pc_out,
    input decode_pkg::aluop_t     aluop,
    input decode_pkg::alusel_t    alusel,
    input decode_pkg::word_t      imm,
    input logic                   reg1_read_en,
    input logic                   reg2_read_en,
    input logic                   reg_write_en,
    input decode_pkg::reg_addr_t  reg1_read_addr,
    input decode_pkg::reg_addr_t  reg2_read_addr,
    input decode_pkg::reg_addr_t  reg_write_addr,
    input logic [2:0]             is_exception_out,
    input decode_pkg::exc_cause_t pc_exception_cause_out,
    input decode_pkg::exc_cause_t instbuffer_exception_cause_out,
    input decode_pkg::exc_cause_t decoder_exception_cause_out,
    input logic                   pre_taken_out,
    input decode_pkg::word_t      pre_addr_out
);
    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid))
        else $error("out_valid is unknown after reset");

    // a stalled beat must not change or vanish
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable({pc_out, aluop, alusel, imm,
            reg1_read_en, reg1_read_addr, reg2_read_en, reg2_read_addr,
            reg_write_en, reg_write_addr, is_exception_out, pc_exception_cause_out,
            instbuffer_exception_cause_out, decoder_exception_cause_out,
            pre_taken_out, pre_addr_out}))
        else $error("outputs changed while stalled");

    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        in_ready == (out_ready || !out_valid))
        else $error("in_ready does not follow out_ready and out_valid");

endmodule

bind decode_stage decode_checker u_decode_checker (.*);

// File: verification/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam int N_FAST  = 200;  // back-to-back phase
    localparam int N_TOTAL = 600;
    localparam int LIMIT   = 4 * N_TOTAL + 200;

    typedef struct packed {
        word_t pc, imm, pa;
        aluop_t aluop;
        alusel_t alusel;
        logic r1en, r2en, wen, pt;
        reg_addr_t r1a, r2a, wa;
        logic [2:0] exc;
        exc_cause_t pcc, ibc, decc;
    } result_t;

    logic clk, rst_n, in_valid, in_ready, out_valid, out_ready, pre_taken, pre_taken_out;
    word_t pc, inst, pre_addr, pc_out, imm, pre_addr_out;
    logic [1:0] is_exception;
    logic [2:0] is_exception_out;
    exc_cause_t pc_exception_cause, instbuffer_exception_cause;
    exc_cause_t pc_exception_cause_out, instbuffer_exception_cause_out;
    exc_cause_t decoder_exception_cause_out;
    aluop_t aluop;
    alusel_t alusel;
    logic reg1_read_en, reg2_read_en, reg_write_en;
    reg_addr_t reg1_read_addr, reg2_read_addr, reg_write_addr;

    result_t expq[$];
    result_t e;
    logic [31:0] rng = 32'h4cc107db;
    int errors = 0, other_errors = 0, received = 0, sent = 0, cycles = 0;
    logic [16:0] op3r[8] = '{OP_ADD_W, OP_SUB_W, OP_SLT, OP_AND, OP_OR, OP_XOR,
                             OP_BREAK, OP_SYSCALL};
    logic [9:0]  op12[6] = '{OP_SLTI, OP_ADDI_W, OP_ANDI, OP_ORI, OP_LD_W, OP_ST_W};
    logic [6:0]  op20[2] = '{OP_LU12I_W, OP_PCADDU12I};
    logic [5:0]  opbr[5] = '{OP_JIRL, OP_B, OP_BL, OP_BEQ, OP_BNE};

    clk_gen u_clk_gen (.clk, .rst_n);
    decode_stage dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic result_t ref_decode(input word_t i, input word_t pcv,
            input logic [1:0] excv, input exc_cause_t pcc, input exc_cause_t ibc,
            input logic pt, input word_t pa);
        result_t r;
        r = '0;
        r.pc = pcv;
        r.pcc = pcc;
        r.ibc = ibc;
        r.pt = pt;
        r.pa = pa;
        for (int k = 0; k < 8; k++) if (i[31:15] == op3r[k]) r.aluop = aluop_t'(k + 1);
        for (int k = 0; k < 6; k++) if (i[31:22] == op12[k]) r.aluop = aluop_t'(k + 9);
        for (int k = 0; k < 2; k++) if (i[31:25] == op20[k]) r.aluop = aluop_t'(k + 15);
        for (int k = 0; k < 5; k++) if (i[31:26] == opbr[k]) r.aluop = aluop_t'(k + 17);
        case (r.aluop)
            ALU_ADD_W, ALU_SUB_W, ALU_SLT, ALU_AND, ALU_OR, ALU_XOR: begin
                r.alusel = (r.aluop inside {ALU_AND, ALU_OR, ALU_XOR}) ? SEL_LOGIC : SEL_ARITH;
                {r.r1en, r.r1a, r.r2en, r.r2a} = {1'b1, i[9:5], 1'b1, i[14:10]};
                {r.wen, r.wa} = {1'b1, i[4:0]};
            end
            ALU_SLTI, ALU_ADDI_W, ALU_ANDI, ALU_ORI, ALU_LD_W, ALU_ST_W: begin
                r.alusel = (r.aluop inside {ALU_ANDI, ALU_ORI}) ? SEL_LOGIC :
                           (r.aluop inside {ALU_LD_W, ALU_ST_W}) ? SEL_MEM : SEL_ARITH;
                r.imm = (r.alusel == SEL_LOGIC) ? {20'd0, i[21:10]} : {{20{i[21]}}, i[21:10]};
                {r.r1en, r.r1a} = {1'b1, i[9:5]};
                if (r.aluop == ALU_ST_W) {r.r2en, r.r2a} = {1'b1, i[4:0]};
                else {r.wen, r.wa} = {1'b1, i[4:0]};
            end
            ALU_LU12I_W, ALU_PCADDU12I: begin
                r.alusel = SEL_ARITH;
                r.imm = {i[24:5], 12'd0};
                {r.wen, r.wa} = {1'b1, i[4:0]};
            end
            ALU_JIRL, ALU_BEQ, ALU_BNE: begin
                r.alusel = SEL_JUMP;
                r.imm = {{14{i[25]}}, i[25:10], 2'b00};
                {r.r1en, r.r1a} = {1'b1, i[9:5]};
                if (r.aluop == ALU_JIRL) {r.wen, r.wa} = {1'b1, i[4:0]};
                else {r.r2en, r.r2a} = {1'b1, i[4:0]};
            end
            ALU_B, ALU_BL: begin
                r.alusel = SEL_JUMP;
                r.imm = {{4{i[9]}}, i[9:0], i[25:10], 2'b00};
                if (r.aluop == ALU_BL) {r.wen, r.wa} = {1'b1, RA};
            end
            ALU_SYSCALL: r.decc = EXC_SYS;
            ALU_BREAK:   r.decc = EXC_BRK;
            default:     r.decc = EXC_INE;
        endcase
        r.exc = {excv, r.decc != EXC_NONE};
        return r;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic new_beat();
        int k;
        rng = xorshift(rng);
        k = int'(rng % 32'd23);  // 21 kept opcodes, two slots of random words
        rng = xorshift(rng);
        inst <= k < 8 ? {op3r[k], rng[14:0]} : k < 14 ? {op12[k - 8], rng[21:0]} :
                k < 16 ? {op20[k - 14], rng[24:0]} : k < 21 ? {opbr[k - 16], rng[25:0]} : rng;
        rng = xorshift(rng);
        {is_exception, pc_exception_cause, instbuffer_exception_cause, pre_taken} <= rng[16:0];
        pc <= {rng[31:2], 2'b00};
        rng = xorshift(rng);
        pre_addr <= rng;
        in_valid <= 1'b1;
    endtask

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: only %0d of %0d beats came out", received, N_TOTAL);
        $display("errors: %0d value mismatches, %0d other failures", errors, other_errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // pop before push, so a beat can never be compared on its own accept edge
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            assert (expq.size() > 0) else begin
                $display("an output beat came out with none expected");
                other_errors++;
            end
            if (expq.size() > 0) begin
                e = expq.pop_front();
                received++;
                check_val("pc_out", pc_out, e.pc);
                check_val("aluop", 32'(aluop), 32'(e.aluop));
                check_val("alusel", 32'(alusel), 32'(e.alusel));
                check_val("imm", imm, e.imm);
                check_val("reg1_read", 32'({reg1_read_en, reg1_read_addr}), 32'({e.r1en, e.r1a}));
                check_val("reg2_read", 32'({reg2_read_en, reg2_read_addr}), 32'({e.r2en, e.r2a}));
                check_val("reg_write", 32'({reg_write_en, reg_write_addr}), 32'({e.wen, e.wa}));
                check_val("is_exception_out", 32'(is_exception_out), 32'(e.exc));
                check_val("pc_exception_cause_out", 32'(pc_exception_cause_out), 32'(e.pcc));
                check_val("instbuffer_exception_cause_out", 32'(instbuffer_exception_cause_out),
                          32'(e.ibc));
                check_val("decoder_exception_cause_out", 32'(decoder_exception_cause_out),
                          32'(e.decc));
                check_val("pre_taken_out", 32'(pre_taken_out), 32'(e.pt));
                check_val("pre_addr_out", pre_addr_out, e.pa);
            end
        end
        if (rst_n && in_valid && in_ready) begin
            expq.push_back(ref_decode(inst, pc, is_exception, pc_exception_cause,
                                      instbuffer_exception_cause, pre_taken, pre_addr));
        end
    end

    initial begin
        {in_valid, out_ready, pre_taken, is_exception} <= '0;
        {pc, inst, pre_addr, pc_exception_cause, instbuffer_exception_cause} <= '0;
        wait (rst_n);
        @(posedge clk);
        assert (out_valid === 1'b0 && in_ready === 1'b1) else begin
            $display("after reset out_valid is not 0 or in_ready is not 1");
            other_errors++;
        end
        out_ready <= 1'b1;
        new_beat();
        while (sent < N_TOTAL) begin
            @(posedge clk);
            if (sent > 0 && sent < N_FAST) begin
                assert (out_valid && in_ready) else begin
                    $display("a back-to-back cycle completed no beat");
                    other_errors++;
                end
            end
            if (in_valid && in_ready) sent++;
            rng = xorshift(rng);
            if (sent >= N_FAST) out_ready <= rng[0] | rng[1];
            if (!in_valid || in_ready) begin
                if (sent < N_TOTAL && (sent < N_FAST || rng[7:6] != 2'b00)) new_beat();
                else in_valid <= 1'b0;
            end
        end
        out_ready <= 1'b1;
        wait (received == N_TOTAL);
        @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", errors, other_errors);
        if (errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/decode_pkg.sv
decoder/dec_3r.sv
decoder/dec_imm_alu.sv
decoder/dec_branch.sv
decoder/decode_ctrl.sv
decoder/decode_stage.sv
verification/clk_gen.sv
verification/decode_checker.sv
verification/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_decode_stage -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1
